// ==== hw/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

        // Width of one memory access.
        typedef enum logic [1:0] {
                SIZE_BYTE = 2'd0,
                SIZE_HALF = 2'd1,
                SIZE_WORD = 2'd2
        } acc_size_e;

        // One data word, seen as byte lanes or as halfword lanes.
        typedef union packed {
                logic [3:0][7:0]        bytes;
                logic [1:0][15:0]       halves;
        } mem_word_u;

        // Wishbone classic master to slave.
        typedef struct packed {
                logic                   cyc;
                logic                   stb;
                logic                   we;
                logic [29:0]            adr;
                logic [3:0]             sel;
                logic [31:0]            dat;
        } wb_req_t;

        // Wishbone classic slave to master.
        typedef struct packed {
                logic                   ack;
                logic                   err;
                logic [31:0]            dat;
        } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hw/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

        // Destination register index width.
        localparam int REG_IDX_W = 6;

        // Raw exception flags carried down the pipe.
        typedef struct packed {
                logic                   und;
                logic                   fiq;
                logic                   irq;
                logic                   swi;
                logic                   iabort;
        } exc_flags_t;

        // Ranked exception code, one per retired operation.
        typedef enum logic [2:0] {
                EXC_NONE   = 3'd0,
                EXC_UND    = 3'd1,
                EXC_FIQ    = 3'd2,
                EXC_IRQ    = 3'd3,
                EXC_SWI    = 3'd4,
                EXC_IABORT = 3'd5,
                EXC_DABORT = 3'd6
        } exc_code_e;

        // One operation from the issue port.
        typedef struct packed {
                logic                   load;
                mem_pkg::acc_size_e     size;
                logic                   is_signed;
                logic [31:0]            addr;
                logic [31:0]            wdata;
                logic [REG_IDX_W-1:0]   dest;
                logic [31:0]            pc;
                exc_flags_t             exc;
        } issue_req_t;

        // Request stage output toward the memory stage.
        typedef struct packed {
                logic                   valid;
                logic                   load;
                mem_pkg::acc_size_e     size;
                logic                   is_signed;
                logic [1:0]             addr_lo;
                logic [31:0]            wdata;
                logic [REG_IDX_W-1:0]   dest;
                logic [31:0]            pc;
                exc_flags_t             exc;
                mem_pkg::mem_word_u     rdata;
                logic                   fault;
        } stage_op_t;

        // Result presented at the retire port.
        typedef struct packed {
                logic                   valid;
                logic                   we;
                logic [REG_IDX_W-1:0]   dest;
                logic [31:0]            data;
                logic [31:0]            pc;
                exc_code_e              code;
        } retire_t;

endpackage

`default_nettype wire

// ==== hw/lsu_request.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_request
(
        input  wire                             i_clk,
        input  wire                             i_reset,
        input  wire                             i_flush,
        input  wire                             i_issue_valid,
        input  wire pipe_pkg::issue_req_t       i_issue,
        output logic                            o_issue_ready,
        output mem_pkg::wb_req_t                o_wb,
        input  wire mem_pkg::wb_rsp_t           i_wb,
        output pipe_pkg::stage_op_t             o_op
);
        import pipe_pkg::*;
        import mem_pkg::*;

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_BUS,
                ST_DONE
        } state_e;

        state_e         state;
        issue_req_t     op_q;
        logic [31:0]    rdata_q;
        logic           fault_q;
        logic           discard;
        logic           accept;
        logic           skip_bus;
        logic           bus_end;
        logic [3:0]     sel;
        logic [31:0]    lanes;

        // No new operation while a bus cycle is open or a flush is pending.
        assign o_issue_ready = (state != ST_BUS) && !i_flush;
        assign accept        = i_issue_valid && o_issue_ready;

        // Operations that already carry an exception never reach the bus.
        assign skip_bus = |i_issue.exc;
        assign bus_end  = i_wb.ack || i_wb.err;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state   <= ST_IDLE;
                        discard <= 1'b0;
                end
                else if (state == ST_BUS)
                begin
                        if (bus_end)
                        begin
                                // A flushed cycle finishes on the bus but is dropped here.
                                state   <= (discard || i_flush) ? ST_IDLE : ST_DONE;
                                discard <= 1'b0;
                        end
                        else if (i_flush)
                        begin
                                discard <= 1'b1;
                        end
                end
                else if (accept)
                begin
                        state <= skip_bus ? ST_DONE : ST_BUS;
                end
                else
                begin
                        state <= ST_IDLE;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (accept)
                begin
                        op_q    <= i_issue;
                        fault_q <= 1'b0;
                end
                else if ((state == ST_BUS) && bus_end)
                begin
                        rdata_q <= i_wb.dat;
                        fault_q <= i_wb.err;
                end
        end

        // Byte selects and replicated store lanes.
        always_comb
        begin
                case (op_q.size)
                SIZE_BYTE:
                begin
                        sel   = 4'b0001 << op_q.addr[1:0];
                        lanes = {4{op_q.wdata[7:0]}};
                end
                SIZE_HALF:
                begin
                        sel   = op_q.addr[1] ? 4'b1100 : 4'b0011;
                        lanes = {2{op_q.wdata[15:0]}};
                end
                default:
                begin
                        sel   = 4'b1111;
                        lanes = op_q.wdata;
                end
                endcase
        end

        always_comb
        begin
                o_wb.cyc = (state == ST_BUS);
                o_wb.stb = (state == ST_BUS);
                o_wb.we  = !op_q.load;
                o_wb.adr = op_q.addr[31:2];
                o_wb.sel = sel;
                o_wb.dat = lanes;
        end

        // The stage link is valid for the single cycle spent in DONE.
        always_comb
        begin
                o_op.valid     = (state == ST_DONE);
                o_op.load      = op_q.load;
                o_op.size      = op_q.size;
                o_op.is_signed = op_q.is_signed;
                o_op.addr_lo   = op_q.addr[1:0];
                o_op.wdata     = op_q.wdata;
                o_op.dest      = op_q.dest;
                o_op.pc        = op_q.pc;
                o_op.exc       = op_q.exc;
                o_op.rdata     = rdata_q;
                o_op.fault     = fault_q;
        end

endmodule

`default_nettype wire

// ==== hw/wb_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_data_ram
#(
        parameter int RAM_WORDS = 256
)
(
        input  wire                     i_clk,
        input  wire                     i_reset,
        input  wire mem_pkg::wb_req_t   i_wb,
        output mem_pkg::wb_rsp_t        o_wb
);
        localparam int IDX_W = $clog2(RAM_WORDS);

        logic [31:0]    mem [RAM_WORDS];
        logic [IDX_W-1:0] idx;
        logic           req;
        logic           in_range;

        // A strobe is new until this slave has answered it.
        assign req      = i_wb.cyc && i_wb.stb && !o_wb.ack && !o_wb.err;
        assign in_range = i_wb.adr < 30'(RAM_WORDS);
        assign idx      = i_wb.adr[IDX_W-1:0];

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_wb.ack <= 1'b0;
                        o_wb.err <= 1'b0;
                end
                else
                begin
                        o_wb.ack <= req && in_range;
                        o_wb.err <= req && !in_range;
                end

                if (req && in_range)
                begin
                        o_wb.dat <= mem[idx];
                end
        end

        // Per-lane writes, only for addresses inside the array.
        always_ff @(posedge i_clk)
        begin
                if (req && in_range && i_wb.we)
                begin
                        for (int l = 0; l < 4; l++)
                        begin
                                if (i_wb.sel[l])
                                begin
                                        mem[idx][l*8 +: 8] <= i_wb.dat[l*8 +: 8];
                                end
                        end
                end
        end

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage
(
        input  wire                             i_clk,
        input  wire                             i_reset,
        input  wire                             i_flush,
        input  wire pipe_pkg::stage_op_t        i_op,
        output pipe_pkg::retire_t               o_retire
);
        import pipe_pkg::*;
        import mem_pkg::*;

        exc_code_e      code;
        logic [31:0]    load_data;
        logic [31:0]    result;

        // Highest ranked cause wins. The bus fault comes last.
        function automatic exc_code_e rank_exc(input exc_flags_t flags, input logic fault);
                exc_code_e c;
                if (flags.und)
                        c = EXC_UND;
                else if (flags.fiq)
                        c = EXC_FIQ;
                else if (flags.irq)
                        c = EXC_IRQ;
                else if (flags.swi)
                        c = EXC_SWI;
                else if (flags.iabort)
                        c = EXC_IABORT;
                else if (fault)
                        c = EXC_DABORT;
                else
                        c = EXC_NONE;
                return c;
        endfunction

        // Pick the addressed lane and extend it, or rotate a full word.
        function automatic logic [31:0] align_load
        (
                input mem_word_u        word,
                input acc_size_e        size,
                input logic             sext,
                input logic [1:0]       addr
        );
                logic [63:0]    twice;
                logic [7:0]     b;
                logic [15:0]    h;
                logic [31:0]    d;
                twice = {word, word};
                b     = word.bytes[addr];
                // Bit 0 is ignored for halfwords.
                h     = word.halves[addr[1]];
                case (size)
                SIZE_BYTE: d = {{24{sext & b[7]}}, b};
                SIZE_HALF: d = {{16{sext & h[15]}}, h};
                default:   d = twice[{addr, 3'b000} +: 32];
                endcase
                return d;
        endfunction

        always_comb
        begin
                code      = rank_exc(i_op.exc, i_op.fault);
                load_data = align_load(i_op.rdata, i_op.size, i_op.is_signed, i_op.addr_lo);
                if (code != EXC_NONE)
                        result = 32'd0;
                else if (i_op.load)
                        result = load_data;
                else
                        result = i_op.wdata;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        o_retire.valid <= 1'b0;
                end
                else
                begin
                        o_retire.valid <= i_op.valid;
                end

                // Only loads without an exception write the register file.
                o_retire.we   <= i_op.load && (code == EXC_NONE);
                o_retire.dest <= i_op.dest;
                o_retire.data <= result;
                o_retire.pc   <= i_op.pc;
                o_retire.code <= code;
        end

endmodule

`default_nettype wire

// ==== hw/load_store_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_top
#(
        parameter int RAM_WORDS = 256
)
(
        input  wire                             i_clk,
        input  wire                             i_reset,
        input  wire                             i_flush,
        input  wire                             i_issue_valid,
        input  wire pipe_pkg::issue_req_t       i_issue,
        output logic                            o_issue_ready,
        output pipe_pkg::retire_t               o_retire
);
        import mem_pkg::*;
        import pipe_pkg::*;

        wb_req_t        wb_req;
        wb_rsp_t        wb_rsp;
        stage_op_t      stage_op;

        lsu_request u_lsu_request
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_flush        (i_flush),
                .i_issue_valid  (i_issue_valid),
                .i_issue        (i_issue),
                .o_issue_ready  (o_issue_ready),
                .o_wb           (wb_req),
                .i_wb           (wb_rsp),
                .o_op           (stage_op)
        );

        // Data RAM sits on the bus beside the pipe.
        wb_data_ram #(
                .RAM_WORDS      (RAM_WORDS)
        ) u_wb_data_ram
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_wb           (wb_req),
                .o_wb           (wb_rsp)
        );

        memory_stage u_memory_stage
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_flush        (i_flush),
                .i_op           (stage_op),
                .o_retire       (o_retire)
        );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
        parameter real PERIOD_NS = 8.0
)
(
        output logic    o_clk
);
        // Free running clock that starts low.
        initial
        begin
                o_clk = 1'b0;
                forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
        end

endmodule

`default_nettype wire

// ==== dv/tb_load_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_load_store;
        import mem_pkg::*;
        import pipe_pkg::*;

        localparam int RAM_WORDS = 256;
        localparam int TIMEOUT_CYCLES = 50;

        logic           clk;
        logic           rst;
        logic           flush;
        logic           issue_valid;
        issue_req_t     issue;
        logic           issue_ready;
        retire_t        retire;
        int             cycle = 0;

        // Byte image of the data RAM with lane 0 at the lowest address.
        logic [7:0]     ref_mem [1024];
        retire_t        exp_q [$];
        int             acc_q [$];

        tb_clock_gen #(
                .PERIOD_NS      (8.0)
        ) clock_gen_inst
        (
                .o_clk          (clk)
        );

        load_store_top #(
                .RAM_WORDS      (RAM_WORDS)
        ) load_store_top_inst
        (
                .i_clk          (clk),
                .i_reset        (rst),
                .i_flush        (flush),
                .i_issue_valid  (issue_valid),
                .i_issue        (issue),
                .o_issue_ready  (issue_ready),
                .o_retire       (retire)
        );

        always @(posedge clk)
        begin
                cycle <= cycle + 1;
        end

        task automatic stop_on_failure(input string why);
                $display("%s", why);
                $display("*** FAILED ***");
                $fatal(1);
        endtask

        task automatic report_mismatch(input string msg);
                stop_on_failure($sformatf("Error at %0d ns: %s", $time, msg));
        endtask

        function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
                return (addr * 32'h9e37_79b1) ^ 32'h5a0f_c3e1;
        endfunction

        function automatic issue_req_t make_op(input logic load, input acc_size_e size,
                input logic sgn, input logic [31:0] addr, input logic [31:0] wdata,
                input exc_flags_t exc);
                issue_req_t     op;
                op.load      = load;
                op.size      = size;
                op.is_signed = sgn;
                op.addr      = addr;
                op.wdata     = wdata;
                op.dest      = REG_IDX_W'($urandom);
                op.pc        = $urandom & 32'hffff_fffc;
                op.exc       = exc;
                return op;
        endfunction

        // Priority is und, fiq, irq, swi, iabort, then the data abort.
        function automatic exc_code_e expect_code(input exc_flags_t f, input logic fault);
                exc_code_e      c;
                casez ({f.und, f.fiq, f.irq, f.swi, f.iabort, fault})
                6'b1?????: c = EXC_UND;
                6'b01????: c = EXC_FIQ;
                6'b001???: c = EXC_IRQ;
                6'b0001??: c = EXC_SWI;
                6'b00001?: c = EXC_IABORT;
                6'b000001: c = EXC_DABORT;
                default:   c = EXC_NONE;
                endcase
                return c;
        endfunction

        function automatic logic [31:0] expect_load(input logic [31:0] addr,
                input acc_size_e size, input logic sgn);
                logic [7:0]     b;
                logic [15:0]    h;
                logic [1:0]     l;
                logic [31:0]    w;
                b = ref_mem[addr[9:0]];
                // Halfword picks ignore address bit 0.
                h = {ref_mem[{addr[9:1], 1'b1}], ref_mem[{addr[9:1], 1'b0}]};
                l = addr[1:0];
                // Word is rotated right so the addressed lane lands in bits 7..0.
                w = {ref_mem[{addr[9:2], l + 2'd3}], ref_mem[{addr[9:2], l + 2'd2}],
                     ref_mem[{addr[9:2], l + 2'd1}], ref_mem[{addr[9:2], l}]};
                case (size)
                SIZE_BYTE: w = sgn ? {{24{b[7]}}, b} : {24'd0, b};
                SIZE_HALF: w = sgn ? {{16{h[15]}}, h} : {16'd0, h};
                default:   w = w;
                endcase
                return w;
        endfunction

        task automatic commit_store(input issue_req_t op);
                case (op.size)
                SIZE_BYTE: ref_mem[op.addr[9:0]] = op.wdata[7:0];
                SIZE_HALF:
                begin
                        ref_mem[{op.addr[9:1], 1'b0}] = op.wdata[7:0];
                        ref_mem[{op.addr[9:1], 1'b1}] = op.wdata[15:8];
                end
                default:
                begin
                        ref_mem[{op.addr[9:2], 2'd0}] = op.wdata[7:0];
                        ref_mem[{op.addr[9:2], 2'd1}] = op.wdata[15:8];
                        ref_mem[{op.addr[9:2], 2'd2}] = op.wdata[23:16];
                        ref_mem[{op.addr[9:2], 2'd3}] = op.wdata[31:24];
                end
                endcase
        endtask

        // Expected retire record. Clean stores update the model here.
        task automatic predict_retire(input issue_req_t op, output retire_t exp);
                logic   fault;
                fault     = (op.exc == '0) && (op.addr[31:2] >= 30'(RAM_WORDS));
                exp.valid = 1'b1;
                exp.dest  = op.dest;
                exp.pc    = op.pc;
                exp.code  = expect_code(op.exc, fault);
                exp.we    = 1'b0;
                exp.data  = 32'd0;
                if (exp.code == EXC_NONE)
                begin
                        if (op.load)
                        begin
                                exp.we   = 1'b1;
                                exp.data = expect_load(op.addr, op.size, op.is_signed);
                        end
                        else
                        begin
                                exp.data = op.wdata;
                                commit_store(op);
                        end
                end
        endtask

        // Returns at the edge that takes the operation. acc is the count just before it.
        task automatic send_op(input issue_req_t op, output int acc);
                int     waited;
                waited = 0;
                @(posedge clk);
                issue_valid <= 1'b1;
                issue       <= op;
                @(negedge clk);
                while (!issue_ready)
                begin
                        waited++;
                        if (waited > TIMEOUT_CYCLES)
                                stop_on_failure("Timeout: the issue port never became ready.");
                        @(negedge clk);
                end
                acc = cycle;
                @(posedge clk);
                issue_valid <= 1'b0;
        endtask

        task automatic wait_retire(output retire_t got, output int at);
                int     waited;
                waited = 0;
                @(negedge clk);
                while (!retire.valid)
                begin
                        waited++;
                        if (waited > TIMEOUT_CYCLES)
                                stop_on_failure("Timeout: no operation retired.");
                        @(negedge clk);
                end
                got = retire;
                at  = cycle;
        endtask

        task automatic check_retire(input retire_t got, input retire_t exp, input int lat,
                input int exp_lat, input string what);
                assert (got.code == exp.code)
                else report_mismatch($sformatf("%s: code %0d, expected %0d",
                        what, got.code, exp.code));
                assert (got.we == exp.we)
                else report_mismatch($sformatf("%s: we %b, expected %b", what, got.we, exp.we));
                assert (got.data == exp.data)
                else report_mismatch($sformatf("%s: data %h, expected %h",
                        what, got.data, exp.data));
                assert ((got.dest == exp.dest) && (got.pc == exp.pc))
                else report_mismatch($sformatf("%s: dest or pc belongs to another op", what));
                assert (lat == exp_lat)
                else report_mismatch($sformatf("%s: retired %0d cycles after issue, expected %0d",
                        what, lat, exp_lat));
        endtask

        task automatic run_op(input issue_req_t op, input string what);
                retire_t        exp;
                retire_t        got;
                int             acc;
                int             at;
                predict_retire(op, exp);
                send_op(op, acc);
                wait_retire(got, at);
                check_retire(got, exp, at - acc, (op.exc != '0) ? 2 : 4, what);
        endtask

        task automatic fill_window();
                logic [31:0]    addr;
                for (int w = 0; w < 32; w++)
                begin
                        addr = 32'(w) << 2;
                        run_op(make_op(1'b0, SIZE_WORD, 1'b0, addr, fill_pattern(addr), '0),
                                "fill store");
                end
        endtask

        task automatic test_word_rotation();
                run_op(make_op(1'b0, SIZE_WORD, 1'b0, 32'h40, 32'hc3a5_8421, '0), "word store");
                for (int i = 0; i < 4; i++)
                        run_op(make_op(1'b1, SIZE_WORD, 1'b0, 32'h40 + 32'(i), 32'd0, '0),
                                "rotated word load");
        endtask

        task automatic test_sub_word();
                for (int i = 0; i < 4; i++)
                        run_op(make_op(1'b0, SIZE_BYTE, 1'b0, 32'h50 + 32'(i),
                                32'h6af1_358c >> (8 * i), '0), "byte store");
                // Upper half of the next word. Address bit 0 is ignored.
                run_op(make_op(1'b0, SIZE_HALF, 1'b0, 32'h57, 32'h1234_9e27, '0), "half store");
                for (int i = 0; i < 16; i++)
                begin
                        run_op(make_op(1'b1, SIZE_BYTE, i[3], 32'h50 + 32'(i[2:0]), 32'd0, '0),
                                "byte load");
                        run_op(make_op(1'b1, SIZE_HALF, i[3], 32'h50 + 32'(i[2:0]), 32'd0, '0),
                                "half load");
                end
        endtask

        task automatic test_exceptions();
                // Each pass drops the top flag, so every rank gets a turn.
                for (int i = 0; i < 5; i++)
                        run_op(make_op(i[0], SIZE_WORD, 1'b0, 32'h60, 32'h7777_1234,
                                exc_flags_t'(5'b11111 >> i)), "flagged op");
                run_op(make_op(1'b1, SIZE_WORD, 1'b0, 32'h60, 32'd0, '0), "load after flagged");
        endtask

        task automatic test_bus_error();
                run_op(make_op(1'b1, SIZE_WORD, 1'b0, 32'h400, 32'd0, '0), "load word 256");
                run_op(make_op(1'b0, SIZE_WORD, 1'b0, 32'h414, 32'h0bad_cafe, '0),
                        "store word 261");
                run_op(make_op(1'b1, SIZE_HALF, 1'b1, 32'h8000_0022, 32'd0, '0), "load far");
                run_op(make_op(1'b1, SIZE_WORD, 1'b0, 32'h14, 32'd0, '0), "load word 5");
        endtask

        task automatic test_flush();
                issue_req_t     op;
                int             acc;
                op = make_op(1'b1, SIZE_WORD, 1'b0, 32'h24, 32'd0, '0);
                send_op(op, acc);
                // Two edges later the load sits in the memory stage.
                @(posedge clk);
                @(posedge clk);
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
                repeat (8)
                begin
                        @(negedge clk);
                        assert (!retire.valid)
                        else report_mismatch("flushed load still retired");
                end
                run_op(make_op(1'b1, SIZE_WORD, 1'b0, 32'h28, 32'd0, '0), "load after flush");
        endtask

        task automatic test_random();
                issue_req_t     op;
                retire_t        exp;
                retire_t        got;
                int             acc;
                int             at;
                fork
                        begin
                                for (int i = 0; i < 40; i++)
                                begin
                                        op = make_op(1'($urandom),
                                                acc_size_e'(2'($urandom_range(2))),
                                                1'($urandom),
                                                {22'd0, 8'($urandom_range(31)), 2'($urandom)},
                                                $urandom, '0);
                                        predict_retire(op, exp);
                                        exp_q.push_back(exp);
                                        send_op(op, acc);
                                        acc_q.push_back(acc);
                                end
                        end
                        begin
                                for (int i = 0; i < 40; i++)
                                begin
                                        wait_retire(got, at);
                                        if (acc_q.size() == 0)
                                                stop_on_failure(
                                                        "An operation retired before it was issued.");
                                        check_retire(got, exp_q.pop_front(),
                                                at - acc_q.pop_front(), 4, "random op");
                                end
                        end
                join
        endtask

        initial
        begin
                void'($urandom(32'hcb5f));
                rst         <= 1'b1;
                flush       <= 1'b0;
                issue_valid <= 1'b0;
                issue       <= '0;
                repeat (16) @(posedge clk);
                rst <= 1'b0;
                @(negedge clk);
                assert (issue_ready && !retire.valid)
                else report_mismatch("ready low or retire valid after reset");
                fill_window();
                test_word_rotation();
                test_sub_word();
                test_exceptions();
                test_bus_error();
                test_flush();
                test_random();
                $display("*** PASSED ***");
                $finish;
        end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/mem_pkg.sv
hw/pipe_pkg.sv
hw/lsu_request.sv
hw/wb_data_ram.sv
hw/memory_stage.sv
hw/load_store_top.sv
dv/tb_clock_gen.sv
dv/tb_load_store.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_load_store
FILELIST := tb.f
OBJDIR   := obj_dir

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)
